/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = yfilt_tb
FILELIST = yfilt.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# the simulation result is decided by the log, not by the exit status
run: compile
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF "** PASS **" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* src/change_capture.sv */
/*
 * change_capture
 * first filter stage, holds the change record, swaps row and
 * column for the second pass and drives the Y memory row request
 */
`timescale 1ns/1ps

module change_capture (
   input  logic             clock,
   input  logic             arst_n,
   input  logic             start,
   input  yfilt_pkg::key_t  chng_row,
   input  yfilt_pkg::key_t  chng_col,
   input  yfilt_pkg::yval_t chng_val,
   input  logic             fetch_req,
   input  logic             pass_swap,
   input  logic             pass_clear,
   output yfilt_pkg::key_t  cur_row,
   output yfilt_pkg::key_t  cur_col,
   output yfilt_pkg::yval_t cur_val,
   output logic             second_pass,
   output yfilt_pkg::key_t  y_row
);
   import yfilt_pkg::*;

   logic busy;     // a record is being worked on
   logic accept;   // start taken this cycle

   // a start in the done cycle is still taken, the sequencer is idle then
   assign accept = start && (!busy || pass_clear);

   always_ff @(posedge clock or negedge arst_n)
   begin
      if (!arst_n)
      begin
         busy        <= 1'b0;
         second_pass <= 1'b0;
      end
      else
      begin
         if (accept)
            busy <= 1'b1;
         else if (pass_clear)
            busy <= 1'b0;

         if (pass_swap)
            second_pass <= 1'b1;
         else if (pass_clear || accept)
            second_pass <= 1'b0;
      end
   end

   always_ff @(posedge clock)
   begin
      if (accept)
      begin
         cur_row <= chng_row;
         cur_col <= chng_col;
         cur_val <= chng_val;
      end
      else if (pass_swap)
      begin
         cur_row <= cur_col;   // second pass looks at the column's row
         cur_col <= cur_row;
      end
   end

   // request built from registered state only
   assign y_row = fetch_req ? cur_row : NO_ROW;

endmodule

/* src/y_pair_sequencer.sv */
/*
 * y_pair_sequencer
 * third filter stage, FSM that issues the diagonal and off-diagonal
 * values to the compute unit and runs the two passes of a change
 */
`timescale 1ns/1ps

module y_pair_sequencer (
   input  logic             clock,
   input  logic             arst_n,
   input  logic             start,
   input  logic             match_valid,
   input  logic             hdr_found,
   input  yfilt_pkg::yval_t diag_val,
   input  yfilt_pkg::yval_t off_val,
   input  yfilt_pkg::yval_t cur_val,
   input  logic             second_pass,
   input  logic             ex_done,
   output logic             fetch_req,
   output logic             pass_swap,
   output logic             pass_clear,
   output yfilt_pkg::yval_t y_val1,
   output yfilt_pkg::yval_t y_val2,
   output logic             ex_en,
   output logic             done
);
   import yfilt_pkg::*;

   seq_state_e state;
   seq_state_e state_nxt;
   yval_t      off_q;       // off-diagonal kept until ex_done
   logic       issue_nxt;
   yval_t      val1_nxt;
   yval_t      val2_nxt;
   logic       pass_end;
   logic       swap_nxt;
   logic       clear_nxt;
   logic       done_nxt;

   always_comb
   begin
      state_nxt = state;
      issue_nxt = 1'b0;
      val1_nxt  = '0;
      val2_nxt  = '0;
      pass_end  = 1'b0;
      swap_nxt  = 1'b0;
      clear_nxt = 1'b0;
      done_nxt  = 1'b0;

      unique case (state)
         S_IDLE:
         begin
            if (start)
               state_nxt = S_FETCH;
         end
         S_FETCH:
         begin
            if (match_valid && hdr_found)
            begin
               issue_nxt = 1'b1;       // diagonal with the change value
               val1_nxt  = diag_val;
               val2_nxt  = cur_val;
               state_nxt = S_WAIT_EX;
            end
            else if (match_valid)
               pass_end = 1'b1;        // no header, nothing to issue
         end
         S_WAIT_EX:
         begin
            if (ex_done)
            begin
               issue_nxt = 1'b1;
               val1_nxt  = off_q;      // zero if the column was absent
               pass_end  = 1'b1;
            end
         end
         S_MATCH:
         begin
            state_nxt = S_FETCH;       // record swapped by now
         end
      endcase

      if (pass_end && second_pass)
      begin
         done_nxt  = 1'b1;
         clear_nxt = 1'b1;
         state_nxt = S_IDLE;
      end
      else if (pass_end)
      begin
         swap_nxt  = 1'b1;
         state_nxt = S_MATCH;
      end
   end

   always_ff @(posedge clock or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state      <= S_IDLE;
         ex_en      <= 1'b0;
         y_val1     <= '0;
         y_val2     <= '0;
         pass_swap  <= 1'b0;
         pass_clear <= 1'b0;
         done       <= 1'b0;
      end
      else
      begin
         state      <= state_nxt;
         ex_en      <= issue_nxt;
         y_val1     <= val1_nxt;   // zero outside an issue
         y_val2     <= val2_nxt;
         pass_swap  <= swap_nxt;
         pass_clear <= clear_nxt;
         done       <= done_nxt;
      end
   end

   always_ff @(posedge clock)
   begin
      if ((state == S_FETCH) && match_valid)
         off_q <= off_val;
   end

   assign fetch_req = (state == S_FETCH);

endmodule

/* src/yfilt_pkg.sv */
/*
 * yfilt_pkg
 * widths, Y memory slot layout and sequencer states for the
 * Y-value filter of the change engine
 */
package yfilt_pkg;

   localparam int KEY_W  = 16;            // row, column or slot key
   localparam int PART_W = 24;            // real or imaginary part
   localparam int VAL_W  = 2 * PART_W;    // real part in the upper half

   // one slot is key above value, slot 3 sits at the top of the word
   localparam int SLOT_W     = KEY_W + VAL_W;
   localparam int SLOT_COUNT = 4;
   localparam int WORD_W     = SLOT_COUNT * SLOT_W;

   // header key: top bits all ones, low bits carry the row number
   localparam int HDR_MARK_W = 3;
   localparam int HDR_ROW_W  = 9;

   typedef logic [KEY_W-1:0]  key_t;
   typedef logic [VAL_W-1:0]  yval_t;
   typedef logic [WORD_W-1:0] word_t;

   localparam key_t NO_ROW = '1;          // request idle

   typedef enum logic [1:0] {
      S_IDLE,     // waiting for a change record
      S_FETCH,    // row requested, waiting for the match result
      S_MATCH,    // turnaround while row and column swap
      S_WAIT_EX   // diagonal issued, waiting for the compute unit
   } seq_state_e;

endpackage

/* src/yfilt_top.sv */
/*
 * yfilt_top
 * Y-value filter, capture, match and sequence stages in a row
 */
`timescale 1ns/1ps

module yfilt_top (
   input  logic             clock,
   input  logic             arst_n,
   input  logic             start,
   input  yfilt_pkg::key_t  chng_row,
   input  yfilt_pkg::key_t  chng_col,
   input  yfilt_pkg::yval_t chng_val,
   input  yfilt_pkg::word_t ymem_data,
   input  logic             ymem_valid,
   input  logic             ex_done,
   output yfilt_pkg::key_t  y_row,
   output yfilt_pkg::yval_t y_val1,
   output yfilt_pkg::yval_t y_val2,
   output logic             ex_en,
   output logic             done
);
   import yfilt_pkg::*;

   key_t  cur_row;
   key_t  cur_col;
   yval_t cur_val;
   logic  second_pass;
   logic  fetch_req;
   logic  pass_swap;
   logic  pass_clear;
   logic  match_valid;
   logic  hdr_found;
   yval_t diag_val;
   yval_t off_val;

   change_capture i_change_capture (
      .clock       (clock),
      .arst_n      (arst_n),
      .start       (start),
      .chng_row    (chng_row),
      .chng_col    (chng_col),
      .chng_val    (chng_val),
      .fetch_req   (fetch_req),
      .pass_swap   (pass_swap),
      .pass_clear  (pass_clear),
      .cur_row     (cur_row),
      .cur_col     (cur_col),
      .cur_val     (cur_val),
      .second_pass (second_pass),
      .y_row       (y_row)
   );

   ymem_entry_match i_ymem_entry_match (
      .clock       (clock),
      .arst_n      (arst_n),
      .ymem_data   (ymem_data),
      .ymem_valid  (ymem_valid),
      .fetch_req   (fetch_req),
      .cur_row     (cur_row),
      .cur_col     (cur_col),
      .match_valid (match_valid),
      .hdr_found   (hdr_found),
      .diag_val    (diag_val),
      .off_val     (off_val)
   );

   y_pair_sequencer i_y_pair_sequencer (
      .clock       (clock),
      .arst_n      (arst_n),
      .start       (start),
      .match_valid (match_valid),
      .hdr_found   (hdr_found),
      .diag_val    (diag_val),
      .off_val     (off_val),
      .cur_val     (cur_val),
      .second_pass (second_pass),
      .ex_done     (ex_done),
      .fetch_req   (fetch_req),
      .pass_swap   (pass_swap),
      .pass_clear  (pass_clear),
      .y_val1      (y_val1),
      .y_val2      (y_val2),
      .ex_en       (ex_en),
      .done        (done)
   );

endmodule

/* src/ymem_entry_match.sv */
/*
 * ymem_entry_match
 * second filter stage, splits a Y memory word into slots, finds the
 * row header and the column entry below it and registers the result
 */
`timescale 1ns/1ps

module ymem_entry_match (
   input  logic             clock,
   input  logic             arst_n,
   input  yfilt_pkg::word_t ymem_data,
   input  logic             ymem_valid,
   input  logic             fetch_req,
   input  yfilt_pkg::key_t  cur_row,
   input  yfilt_pkg::key_t  cur_col,
   output logic             match_valid,
   output logic             hdr_found,
   output yfilt_pkg::yval_t diag_val,
   output yfilt_pkg::yval_t off_val
);
   import yfilt_pkg::*;

   key_t  slot_key [SLOT_COUNT];
   yval_t slot_val [SLOT_COUNT];
   logic  hdr_hit;
   int    hdr_idx;     // slot holding the header
   yval_t hdr_val_c;
   logic  off_hit;
   yval_t off_val_c;
   logic  take;        // word belongs to the current request

   function automatic logic is_header(key_t key, key_t row);
      return (&key[KEY_W-1 -: HDR_MARK_W]) &&
             (key[HDR_ROW_W-1:0] == row[HDR_ROW_W-1:0]);
   endfunction

   always_comb
   begin
      for (int i = 0; i < SLOT_COUNT; i++)
      begin
         slot_key[i] = ymem_data[i*SLOT_W + VAL_W +: KEY_W];
         slot_val[i] = ymem_data[i*SLOT_W +: VAL_W];
      end
   end

   // highest header of this row wins
   always_comb
   begin
      hdr_hit   = 1'b0;
      hdr_idx   = 0;
      hdr_val_c = '0;
      for (int i = SLOT_COUNT - 1; i >= 0; i--)
      begin
         if (!hdr_hit && is_header(slot_key[i], cur_row))
         begin
            hdr_hit   = 1'b1;
            hdr_idx   = i;
            hdr_val_c = slot_val[i];
         end
      end
   end

   // off-diagonal only counts below the header
   always_comb
   begin
      off_hit   = 1'b0;
      off_val_c = '0;
      for (int i = SLOT_COUNT - 1; i >= 0; i--)
      begin
         if (hdr_hit && !off_hit && (i < hdr_idx) && (slot_key[i] == cur_col))
         begin
            off_hit   = 1'b1;
            off_val_c = slot_val[i];
         end
      end
   end

   assign take = ymem_valid && fetch_req;

   always_ff @(posedge clock or negedge arst_n)
   begin
      if (!arst_n)
      begin
         match_valid <= 1'b0;
         hdr_found   <= 1'b0;
      end
      else
      begin
         match_valid <= take;   // one-cycle result strobe
         if (take)
            hdr_found <= hdr_hit;
      end
   end

   always_ff @(posedge clock)
   begin
      if (take)
      begin
         diag_val <= hdr_val_c;   // zero when no header
         off_val  <= off_val_c;
      end
   end

endmodule

/* test/yfilt_properties.sv */
/*
 * yfilt_properties
 * concurrent checks on the issue outputs and the row request,
 * bound to the filter top level
 */
`timescale 1ns/1ps

module yfilt_properties (
   input logic                   clock,
   input logic                   arst_n,
   input logic                   start,
   input logic                   ex_en,
   input logic                   done,
   input yfilt_pkg::yval_t       y_val1,
   input yfilt_pkg::yval_t       y_val2,
   input yfilt_pkg::key_t        y_row,
   input yfilt_pkg::seq_state_e  state
);
   import yfilt_pkg::*;

   int fail_count = 0;   // failed assertions so far

   // done only rides on the off-diagonal issue, the last one
   last_issue_a : assert property (@(posedge clock) disable iff (!arst_n)
      (ex_en && done) |-> (y_val2 == '0))
   else
   begin
      $error("done came with a diagonal issue");
      fail_count++;
   end

   quiet_vals_a : assert property (@(posedge clock) disable iff (!arst_n)
      !ex_en |-> ((y_val1 == '0) && (y_val2 == '0)))
   else
   begin
      $error("issue values not zero while ex_en is low");
      fail_count++;
   end

   done_pulse_a : assert property (@(posedge clock) disable iff (!arst_n)
      done |=> !done)
   else
   begin
      $error("done held for more than one cycle");
      fail_count++;
   end

   // idle without a start keeps the request off
   idle_row_a : assert property (@(posedge clock) disable iff (!arst_n)
      ((state == S_IDLE) && !start) |=> (y_row == NO_ROW))
   else
   begin
      $error("row requested while the sequencer is idle");
      fail_count++;
   end

endmodule

bind yfilt_top yfilt_properties i_yfilt_properties (
   .clock  (clock),
   .arst_n (arst_n),
   .start  (start),
   .ex_en  (ex_en),
   .done   (done),
   .y_val1 (y_val1),
   .y_val2 (y_val2),
   .y_row  (y_row),
   .state  (i_y_pair_sequencer.state)
);

/* test/yfilt_tb.sv */
/*
 * yfilt_tb
 * directed testbench for the Y-value filter, models the Y memory
 * and the compute unit and checks both passes of every change
 */
`timescale 1ns/1ps

module yfilt_tb;
   import yfilt_pkg::*;

   localparam int   RESET_CYC   = 10;
   localparam int   MEM_MAX     = 5;       // short random delays
   localparam int   LONG_DLY    = 30;
   localparam int   PASS_CYC    = 8 + 2 * MEM_MAX;
   localparam int   LONG_CYC    = 8 + 2 * LONG_DLY;
   localparam int   CYCLE_LIMIT = RESET_CYC + 18 * PASS_CYC + 2 * LONG_CYC + 20;
   localparam key_t FILL_KEY    = 16'h1fff;   // neither a header nor a column

   logic  clock = 1'b0;
   logic  arst_n;
   logic  start;
   key_t  chng_row;
   key_t  chng_col;
   yval_t chng_val;
   word_t ymem_data;
   logic  ymem_valid;
   logic  ex_done;
   key_t  y_row;
   yval_t y_val1;
   yval_t y_val2;
   logic  ex_en;
   logic  done;
   int    cycles = 0;

   yfilt_top i_yfilt_top (.*);

   initial
   begin
      forever
         #5 clock = ~clock;
   end

   always @(posedge clock)
   begin
      cycles <= cycles + 1;
      if (i_yfilt_top.i_yfilt_properties.fail_count != 0)
      begin
         $display("A property check failed before %0t", $time);
         fail_now();
      end
      else if (cycles >= CYCLE_LIMIT)
      begin
         $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
         fail_now();
      end
   end

   task automatic fail_now();
      $display("** FAIL **");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_val(yval_t got, yval_t exp, string what);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
         fail_now();
      end
   endtask

   task automatic check_row(key_t got, key_t exp, string what);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
         fail_now();
      end
   endtask

   task automatic check_bit(logic got, logic exp, string what);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: %s, got %b expected %b", $time, what, got, exp);
         fail_now();
      end
   endtask

   function automatic yval_t rand_val();
      return {16'($urandom), $urandom};
   endfunction

   // top marker bits set, row number in the low bits
   function automatic key_t hdr_key(key_t row);
      key_t key;
      key = '0;
      key[KEY_W-1 -: HDR_MARK_W] = '1;
      key[HDR_ROW_W-1:0] = row[HDR_ROW_W-1:0];
      return key;
   endfunction

   function automatic void put_slot(inout word_t w, input int slot, input key_t key,
                                    input yval_t val);
      w[slot*SLOT_W +: SLOT_W] = {key, val};   // key above value
   endfunction

   // slot -1 leaves that entry out
   function automatic word_t build_word(int hdr_slot, key_t hkey, yval_t hval,
                                        int col_slot, key_t ckey, yval_t cval,
                                        int decoy_slot);
      word_t w;
      for (int i = 0; i < SLOT_COUNT; i++)
         put_slot(w, i, FILL_KEY, rand_val());
      if (decoy_slot >= 0)
         put_slot(w, decoy_slot, ckey, rand_val());
      if (col_slot >= 0)
         put_slot(w, col_slot, ckey, cval);
      if (hdr_slot >= 0)
         put_slot(w, hdr_slot, hkey, hval);
      return w;
   endfunction

   task automatic pulse_start(key_t row, key_t col, yval_t val);
      start    = 1'b1;
      chng_row = row;
      chng_col = col;
      chng_val = val;
      @(negedge clock);
      start = 1'b0;
   endtask

   // memory model, one strobe per request
   task automatic respond_mem(word_t w, key_t row, int dly);
      while (y_row == NO_ROW)
         @(negedge clock);
      check_row(y_row, row, "row request");
      repeat (dly) @(negedge clock);
      check_row(y_row, row, "row request held");
      ymem_data  = w;
      ymem_valid = 1'b1;
      @(negedge clock);
      ymem_valid = 1'b0;
   endtask

   // compute unit model
   task automatic return_ex_done(int dly);
      for (int i = 0; i < dly; i++)
      begin
         @(negedge clock);
         check_bit(ex_en, 1'b0, "ex_en while compute unit busy");
      end
      ex_done = 1'b1;
      @(negedge clock);
      ex_done = 1'b0;
   endtask

   task automatic run_pass(word_t w, logic hdr, yval_t diag, yval_t off, yval_t val,
                           key_t row, logic last, int dly_min, int dly_max);
      respond_mem(w, row, $urandom_range(dly_max, dly_min));
      check_bit(ex_en, 1'b0, "ex_en one cycle after ymem_valid");
      @(negedge clock);
      if (hdr)
      begin
         check_bit(ex_en, 1'b1, "diagonal issue two cycles after ymem_valid");
         check_val(y_val1, diag, "diagonal value");
         check_val(y_val2, val, "change value with the diagonal");
         check_bit(done, 1'b0, "done with the diagonal issue");
         return_ex_done($urandom_range(dly_max, dly_min));
         check_bit(ex_en, 1'b1, "off-diagonal issue after ex_done");
         check_val(y_val1, off, "off-diagonal value");
         check_val(y_val2, '0, "second value with the off-diagonal");
      end
      else
         check_bit(ex_en, 1'b0, "issue without a header");
      check_bit(done, last, "done at the end of the pass");
   endtask

   // slots per pass: header, column, decoy above the header
   task automatic run_change(int h1, int c1, int x1, int h2, int c2, int x2,
                             int dly_min, int dly_max, logic poke);
      key_t  row = key_t'($urandom_range(4095, 0));
      key_t  col = row ^ key_t'($urandom_range(511, 1));   // other low bits
      yval_t val = rand_val();
      yval_t d1  = rand_val();
      yval_t o1  = rand_val();
      yval_t d2  = rand_val();
      yval_t o2  = rand_val();
      pulse_start(row, col, val);
      check_row(y_row, row, "row request one cycle after start");
      if (poke)
         pulse_start(~row, ~col, ~val);   // busy, must be dropped
      run_pass(build_word(h1, hdr_key(row), d1, c1, col, o1, x1), h1 >= 0, d1,
               (c1 >= 0) ? o1 : '0, val, row, 1'b0, dly_min, dly_max);
      run_pass(build_word(h2, hdr_key(col), d2, c2, row, o2, x2), h2 >= 0, d2,
               (c2 >= 0) ? o2 : '0, val, col, 1'b1, dly_min, dly_max);
   endtask

   task automatic test_reset();
      check_bit(ex_en, 1'b0, "ex_en after reset");
      check_bit(done, 1'b0, "done after reset");
      check_row(y_row, NO_ROW, "y_row after reset");
   endtask

   task automatic test_two_pass();
      repeat (2) run_change(3, 1, -1, 2, 0, -1, 0, MEM_MAX, 1'b0);
   endtask

   task automatic test_no_off();
      run_change(1, -1, 3, 3, -1, -1, 0, MEM_MAX, 1'b0);
   endtask

   task automatic test_slot_order();
      int h1;
      int h2;
      repeat (4)
      begin
         h1 = $urandom_range(3, 1);
         h2 = $urandom_range(3, 1);
         run_change(h1, $urandom_range(h1 - 1, 0), (h1 < 3) ? 3 : -1,
                    h2, $urandom_range(h2 - 1, 0), (h2 < 3) ? 3 : -1,
                    0, MEM_MAX, 1'b0);
      end
   endtask

   task automatic test_no_header();
      run_change(-1, 1, -1, -1, 2, -1, 0, MEM_MAX, 1'b0);
      run_change(-1, -1, -1, 2, 0, -1, 0, MEM_MAX, 1'b0);
   endtask

   task automatic test_ignored_start();
      run_change(3, 2, -1, 1, 0, -1, LONG_DLY / 2, LONG_DLY, 1'b1);
   endtask

   initial
   begin
      void'($urandom(32'h192e_6c23));
      arst_n     = 1'b0;
      start      = 1'b0;
      chng_row   = '0;
      chng_col   = '0;
      chng_val   = '0;
      ymem_data  = '0;
      ymem_valid = 1'b0;
      ex_done    = 1'b0;
      repeat (RESET_CYC) @(negedge clock);
      arst_n = 1'b1;
      test_reset();
      test_two_pass();
      test_no_off();
      test_slot_order();
      test_no_header();
      test_ignored_start();
      @(negedge clock);
      if (i_yfilt_top.i_yfilt_properties.fail_count == 0)
      begin
         $display("** PASS **");
         $finish;
      end
      else
      begin
         $display("%0d property checks failed", i_yfilt_top.i_yfilt_properties.fail_count);
         fail_now();
      end
   end

endmodule

/* yfilt.f */
src/yfilt_pkg.sv
src/change_capture.sv
src/ymem_entry_match.sv
src/y_pair_sequencer.sv
src/yfilt_top.sv
test/yfilt_properties.sv
test/yfilt_tb.sv
